// File: componentSerializer.sv
`timescale 1ns/1ps
`include "ycc_defines.svh"

module componentSerializer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 yccValid,
    input  logic [`WORD_W-1:0]   yWord,
    input  logic [`WORD_W-1:0]   cbWord,
    input  logic [`WORD_W-1:0]   crWord,
    output logic [`WORD_W-1:0]   dataWrite,
    output logic [`ADDR_W-1:0]   sramWaddr,
    output logic                 wen,
    output logic                 valid,
    output logic                 runDone
);
    import ycc_pkg::*;

    localparam logic [`ADDR_W-1:0] lastAddr = 3 * `NUM_BLOCKS - 1;

    // PLANE_R waits for Y, PLANE_G has Cb pending, PLANE_B has Cr pending
    plane_t phase;

    logic [`WORD_W-1:0] cbHold;
    logic [`WORD_W-1:0] crHold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase     <= PLANE_R;
            wen       <= 1'b1;
            sramWaddr <= '0;
            valid     <= 1'b0;
        end else begin
            valid <= 1'b0;
            // address moves on after every completed write
            if (!wen) begin
                if (sramWaddr == lastAddr) begin
                    sramWaddr <= '0;
                    valid     <= 1'b1;
                end else begin
                    sramWaddr <= sramWaddr + 1'b1;
                end
            end
            unique case (phase)
                PLANE_G: begin
                    wen   <= 1'b0;
                    phase <= PLANE_B;
                end
                PLANE_B: begin
                    wen   <= 1'b0;
                    phase <= PLANE_R;
                end
                default: begin
                    wen <= !yccValid;
                    if (yccValid) begin
                        phase <= PLANE_G;
                    end
                end
            endcase
        end
    end

    // write data follows the phase, Y goes straight through
    always_ff @(posedge clk) begin
        if (yccValid) begin
            cbHold <= cbWord;
            crHold <= crWord;
        end
        unique case (phase)
            PLANE_G: dataWrite <= cbHold;
            PLANE_B: dataWrite <= crHold;
            default: dataWrite <= yWord;
        endcase
    end

    // sequencer leaves DRAIN on the done pulse
    assign runDone = valid;

    // groups are three cycles apart, so a new one never hits a pending Cb or Cr
    noOverlap: assert property (@(posedge clk) disable iff (!rst_n)
        yccValid |-> phase == PLANE_R)
        else $error("converted group arrived while Cb or Cr still pending");

endmodule

// File: convArray.sv
`timescale 1ns/1ps
`include "ycc_defines.svh"

module convArray (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 tripletValid,
    input  logic [`WORD_W-1:0]   rWord,
    input  logic [`WORD_W-1:0]   gWord,
    input  logic [`WORD_W-1:0]   bWord,
    output logic [`WORD_W-1:0]   yWord,
    output logic [`WORD_W-1:0]   cbWord,
    output logic [`WORD_W-1:0]   crWord,
    output logic                 yccValid
);

    // one bit per converter stage, groups may overlap
    logic [`CONV_LAT-1:0] validPipe;

    for (genvar i = 0; i < `LANES; i++) begin : gLane
        pixelConverter uConv (
            .clk (clk),
            .r   (rWord[i*`PIX_W +: `PIX_W]),
            .g   (gWord[i*`PIX_W +: `PIX_W]),
            .b   (bWord[i*`PIX_W +: `PIX_W]),
            .y   (yWord[i*`PIX_W +: `PIX_W]),
            .cb  (cbWord[i*`PIX_W +: `PIX_W]),
            .cr  (crWord[i*`PIX_W +: `PIX_W])
        );
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[`CONV_LAT-2:0], tripletValid};
        end
    end

    assign yccValid = validPipe[`CONV_LAT-1];

endmodule

// File: pixelConverter.sv
`timescale 1ns/1ps
`include "ycc_defines.svh"

module pixelConverter (
    input  logic              clk,
    input  ycc_pkg::pixel_t   r,
    input  ycc_pkg::pixel_t   g,
    input  ycc_pkg::pixel_t   b,
    output ycc_pkg::pixel_t   y,
    output ycc_pkg::pixel_t   cb,
    output ycc_pkg::pixel_t   cr
);

    // samples widened to signed with a zero sign bit
    logic signed [`PIX_W:0] rS;
    logic signed [`PIX_W:0] gS;
    logic signed [`PIX_W:0] bS;

    // stage 1, signed products
    logic signed [17:0] yR, yG, yB;
    logic signed [17:0] cbR, cbG, cbB;
    logic signed [17:0] crR, crG, crB;

    // stage 2, rounded sums
    logic signed [17:0] ySum;
    logic signed [17:0] cbSum;
    logic signed [17:0] crSum;

    // stage 3 before truncation
    logic signed [17:0] yFull;
    logic signed [17:0] cbFull;
    logic signed [17:0] crFull;

    assign rS = $signed({1'b0, r});
    assign gS = $signed({1'b0, g});
    assign bS = $signed({1'b0, b});

    always_ff @(posedge clk) begin
        yR  <= 18'sd66 * rS;
        yG  <= 18'sd129 * gS;
        yB  <= 18'sd25 * bS;
        cbR <= -18'sd38 * rS;
        cbG <= -18'sd74 * gS;
        cbB <= 18'sd112 * bS;
        crR <= 18'sd112 * rS;
        crG <= -18'sd94 * gS;
        crB <= -18'sd18 * bS;
    end

    // 128 rounds the divide by 256
    always_ff @(posedge clk) begin
        ySum  <= yR + yG + yB + 18'sd128;
        cbSum <= cbR + cbG + cbB + 18'sd128;
        crSum <= crR + crG + crB + 18'sd128;
    end

    assign yFull  = (ySum >>> 8) + 18'sd16;
    assign cbFull = (cbSum >>> 8) + 18'sd128;
    assign crFull = (crSum >>> 8) + 18'sd128;

    // results stay in 16..240 so the low bits are exact
    always_ff @(posedge clk) begin
        y  <= yFull[`PIX_W-1:0];
        cb <= cbFull[`PIX_W-1:0];
        cr <= crFull[`PIX_W-1:0];
    end

endmodule

// File: planeAligner.sv
`timescale 1ns/1ps
`include "ycc_defines.svh"

module planeAligner (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rdActive,
    input  ycc_pkg::plane_t      rdPlane,
    input  logic [`WORD_W-1:0]   dataRead,
    output logic [`WORD_W-1:0]   rWord,
    output logic [`WORD_W-1:0]   gWord,
    output logic [`WORD_W-1:0]   bWord,
    output logic                 tripletValid
);
    import ycc_pkg::*;

    // read tag delayed to line up with the sram return
    logic   activeD;
    plane_t planeD;

    // R and G words waiting for their B word
    logic [`WORD_W-1:0] rHold;
    logic [`WORD_W-1:0] gHold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            activeD      <= 1'b0;
            planeD       <= PLANE_R;
            tripletValid <= 1'b0;
        end else begin
            activeD      <= rdActive;
            planeD       <= rdPlane;
            tripletValid <= activeD && (planeD == PLANE_B);
        end
    end

    always_ff @(posedge clk) begin
        if (activeD) begin
            unique case (planeD)
                PLANE_R: rHold <= dataRead;
                PLANE_G: gHold <= dataRead;
                default: begin
                    // B landed, release the whole group
                    rWord <= rHold;
                    gWord <= gHold;
                    bWord <= dataRead;
                end
            endcase
        end
    end

endmodule

// File: src.f
+incdir+.
ycc_pkg.sv
ycbcrSequencer.sv
planeAligner.sv
pixelConverter.sv
convArray.sv
componentSerializer.sv
ycbcrBlockTop.sv
ycbcrSramModel.sv
tb_ycbcrBlockTop.sv

// File: tb_ycbcrBlockTop.sv
`timescale 1ns/1ps
`include "ycc_defines.svh"

module tb_ycbcrBlockTop;

    localparam int numWords = 3 * `NUM_BLOCKS;
    // cycles one run may take, pipeline fill included
    localparam int runCycles = numWords + 20;
    // reset, two idle stretches and five runs with a margin of four
    localparam int limitCycles = 16 + 2 * runCycles + 5 * 4 * runCycles;

    logic                clk;
    logic                rst_n;
    logic                enable;
    logic [`WORD_W-1:0]  dataRead;
    logic [`ADDR_W-1:0]  sramRaddr;
    logic [`ADDR_W-1:0]  sramWaddr;
    logic [`WORD_W-1:0]  dataWrite;
    logic                wen;
    logic                valid;

    ycbcrBlockTop dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .dataRead  (dataRead),
        .sramRaddr (sramRaddr),
        .sramWaddr (sramWaddr),
        .dataWrite (dataWrite),
        .wen       (wen),
        .valid     (valid)
    );

    ycbcrSramModel sram (
        .clk   (clk),
        .rAddr (sramRaddr),
        .rData (dataRead),
        .wAddr (sramWaddr),
        .wData (dataWrite),
        .wen   (wen)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic failNow(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "stopping at the first error");
    endtask

    initial begin
        repeat (limitCycles) @(posedge clk);
        failNow("watchdog expired before the tests finished");
    end

    // BT.601 integer rule, arithmetic shift on signed sums
    function automatic void convertPixel(input int r, input int g, input int b,
                                         output int y, output int cb, output int cr);
        y  = ((66 * r + 129 * g + 25 * b + 128) >>> 8) + 16;
        cb = ((-38 * r - 74 * g + 112 * b + 128) >>> 8) + 128;
        cr = ((112 * r - 94 * g - 18 * b + 128) >>> 8) + 128;
    endfunction

    task automatic setPixel(input int k, input int lane, input int r, input int g, input int b);
        sram.imageMem[3*k][lane*`PIX_W +: `PIX_W]   = r[`PIX_W-1:0];
        sram.imageMem[3*k+1][lane*`PIX_W +: `PIX_W] = g[`PIX_W-1:0];
        sram.imageMem[3*k+2][lane*`PIX_W +: `PIX_W] = b[`PIX_W-1:0];
    endtask

    task automatic loadRandomImage();
        for (int k = 0; k < `NUM_BLOCKS; k++) begin
            for (int i = 0; i < `LANES; i++) begin
                setPixel(k, i, $urandom & 8'hff, $urandom & 8'hff, $urandom & 8'hff);
            end
        end
    endtask

    task automatic checkImage();
        int r, g, b, y, cb, cr;
        logic [`WORD_W-1:0] expWord [3];
        logic [`WORD_W-1:0] gotWord;
        string label;
        for (int k = 0; k < `NUM_BLOCKS; k++) begin
            for (int i = 0; i < `LANES; i++) begin
                r = sram.imageMem[3*k][i*`PIX_W +: `PIX_W];
                g = sram.imageMem[3*k+1][i*`PIX_W +: `PIX_W];
                b = sram.imageMem[3*k+2][i*`PIX_W +: `PIX_W];
                convertPixel(r, g, b, y, cb, cr);
                expWord[0][i*`PIX_W +: `PIX_W] = y[`PIX_W-1:0];
                expWord[1][i*`PIX_W +: `PIX_W] = cb[`PIX_W-1:0];
                expWord[2][i*`PIX_W +: `PIX_W] = cr[`PIX_W-1:0];
            end
            for (int c = 0; c < 3; c++) begin
                gotWord = sram.outMem[3*k+c];
                label = (c == 0) ? "Y" : (c == 1) ? "Cb" : "Cr";
                assert (gotWord === expWord[c])
                    else failNow($sformatf("FAILED dataWrite %s at %h: got %h expected %h",
                                           label, 3*k+c, gotWord, expWord[c]));
            end
        end
    endtask

    // one run from enable to valid, watching every write on the way
    task automatic runAndTrack(input int pulseAt);
        int cycle;
        int expAddr;
        int startCount;
        bit prevFinal;
        bit done;
        cycle = 0;
        expAddr = 0;
        prevFinal = 1'b0;
        done = 1'b0;
        startCount = sram.writeCount;
        sram.clearOutput();
        @(negedge clk);
        enable = 1'b1;
        while (!done) begin
            @(negedge clk);
            enable = (cycle == pulseAt);
            cycle++;
            assert (cycle <= runCycles) else failNow("valid did not arrive within the run time");
            if (valid) begin
                assert (prevFinal) else failNow("valid did not follow the last write");
                assert (sram.writeCount - startCount == numWords)
                    else failNow($sformatf("FAILED write count: got %h expected %h",
                                           sram.writeCount - startCount, numWords));
                done = 1'b1;
            end
            if (!wen) begin
                assert (sramWaddr == expAddr)
                    else failNow($sformatf("FAILED sramWaddr: got %h expected %h",
                                           sramWaddr, expAddr));
                expAddr++;
            end
            prevFinal = !wen && (sramWaddr == numWords - 1);
        end
        enable = 1'b0;
        @(negedge clk);
        assert (valid == 1'b0) else failNow($sformatf("FAILED valid: got %h expected 0", valid));
    endtask

    // nothing may be read or written while enable stays low
    task automatic expectIdle(input int cycles);
        int startCount;
        startCount = sram.writeCount;
        repeat (cycles) begin
            @(negedge clk);
            assert (wen == 1'b1) else failNow($sformatf("FAILED wen: got %h expected 1", wen));
            assert (valid == 1'b0) else failNow($sformatf("FAILED valid: got %h expected 0", valid));
            assert (sramRaddr == 0)
                else failNow($sformatf("FAILED sramRaddr: got %h expected 0", sramRaddr));
        end
        assert (sram.writeCount == startCount) else failNow("writes happened while idle");
    endtask

    task automatic runCornerColours();
        int sel;
        for (int k = 0; k < `NUM_BLOCKS; k++) begin
            for (int i = 0; i < `LANES; i++) begin
                sel = (k + i) % 6;
                case (sel)
                    0: setPixel(k, i, 0, 0, 0);
                    1: setPixel(k, i, 255, 255, 255);
                    2: setPixel(k, i, 255, 0, 0);
                    3: setPixel(k, i, 0, 255, 0);
                    4: setPixel(k, i, 0, 0, 255);
                    default: setPixel(k, i, i * 36, 255 - i * 36, (k * 16 + i * 29) % 256);
                endcase
            end
        end
        runAndTrack(-1);
        checkImage();
    endtask

    task automatic runRandomImage();
        loadRandomImage();
        runAndTrack(-1);
        checkImage();
    endtask

    task automatic runWriteAccounting();
        loadRandomImage();
        // address order, write count and the valid pulse are checked per cycle
        runAndTrack(-1);
        checkImage();
    endtask

    task automatic runRestart();
        loadRandomImage();
        // enable pulse lands while the reads are still going
        runAndTrack(10);
        checkImage();
        expectIdle(numWords + 10);
        loadRandomImage();
        runAndTrack(-1);
        checkImage();
    endtask

    initial begin
        void'($urandom(32'h774d));
        rst_n = 1'b0;
        enable = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        expectIdle(20);
        runCornerColours();
        runRandomImage();
        runWriteAccounting();
        runRestart();
        $display("Regression passed");
        $finish;
    end

endmodule

// File: ycbcrBlockTop.sv
`timescale 1ns/1ps
`include "ycc_defines.svh"

module ycbcrBlockTop (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 enable,
    input  logic [`WORD_W-1:0]   dataRead,
    output logic [`ADDR_W-1:0]   sramRaddr,
    output logic [`ADDR_W-1:0]   sramWaddr,
    output logic [`WORD_W-1:0]   dataWrite,
    output logic                 wen,
    output logic                 valid
);
    import ycc_pkg::*;

    // read side
    logic   rdActive;
    plane_t rdPlane;

    // aligned groups into the converters
    logic [`WORD_W-1:0] rWord;
    logic [`WORD_W-1:0] gWord;
    logic [`WORD_W-1:0] bWord;
    logic               tripletValid;

    // converted groups into the serialiser
    logic [`WORD_W-1:0] yWord;
    logic [`WORD_W-1:0] cbWord;
    logic [`WORD_W-1:0] crWord;
    logic               yccValid;

    logic runDone;

    ycbcrSequencer uSeq (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .runDone   (runDone),
        .sramRaddr (sramRaddr),
        .rdActive  (rdActive),
        .rdPlane   (rdPlane)
    );

    planeAligner uAlign (
        .clk          (clk),
        .rst_n        (rst_n),
        .rdActive     (rdActive),
        .rdPlane      (rdPlane),
        .dataRead     (dataRead),
        .rWord        (rWord),
        .gWord        (gWord),
        .bWord        (bWord),
        .tripletValid (tripletValid)
    );

    convArray uConv (
        .clk          (clk),
        .rst_n        (rst_n),
        .tripletValid (tripletValid),
        .rWord        (rWord),
        .gWord        (gWord),
        .bWord        (bWord),
        .yWord        (yWord),
        .cbWord       (cbWord),
        .crWord       (crWord),
        .yccValid     (yccValid)
    );

    componentSerializer uSer (
        .clk       (clk),
        .rst_n     (rst_n),
        .yccValid  (yccValid),
        .yWord     (yWord),
        .cbWord    (cbWord),
        .crWord    (crWord),
        .dataWrite (dataWrite),
        .sramWaddr (sramWaddr),
        .wen       (wen),
        .valid     (valid),
        .runDone   (runDone)
    );

endmodule

// File: ycbcrSequencer.sv
`timescale 1ns/1ps
`include "ycc_defines.svh"

module ycbcrSequencer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 enable,
    input  logic                 runDone,
    output logic [`ADDR_W-1:0]   sramRaddr,
    output logic                 rdActive,
    output ycc_pkg::plane_t      rdPlane
);
    import ycc_pkg::*;

    // last read address of a run
    localparam logic [`ADDR_W-1:0] lastAddr = 3 * `NUM_BLOCKS - 1;

    seqState_t state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            sramRaddr <= '0;
            rdActive  <= 1'b0;
            rdPlane   <= PLANE_R;
        end else begin
            unique case (state)
                IDLE: begin
                    if (enable) begin
                        state     <= READ;
                        sramRaddr <= '0;
                        rdActive  <= 1'b1;
                        rdPlane   <= PLANE_R;
                    end
                end
                READ: begin
                    if (sramRaddr == lastAddr) begin
                        // wait for the write side once every group is issued
                        state     <= DRAIN;
                        sramRaddr <= '0;
                        rdActive  <= 1'b0;
                        rdPlane   <= PLANE_R;
                    end else begin
                        sramRaddr <= sramRaddr + 1'b1;
                        unique case (rdPlane)
                            PLANE_R: rdPlane <= PLANE_G;
                            PLANE_G: rdPlane <= PLANE_B;
                            default: rdPlane <= PLANE_R;
                        endcase
                    end
                end
                DRAIN: begin
                    if (runDone) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // R, G and B words of a group are issued back to back
    rThenG: assert property (@(posedge clk) disable iff (!rst_n)
        rdActive && rdPlane == PLANE_R |=> rdActive && rdPlane == PLANE_G)
        else $error("G word did not follow R word");

    gThenB: assert property (@(posedge clk) disable iff (!rst_n)
        rdActive && rdPlane == PLANE_G |=> rdActive && rdPlane == PLANE_B)
        else $error("B word did not follow G word");

endmodule

// File: ycbcrSramModel.sv
`timescale 1ns/1ps
`include "ycc_defines.svh"

module ycbcrSramModel (
    input  logic                 clk,
    input  logic [`ADDR_W-1:0]   rAddr,
    output logic [`WORD_W-1:0]   rData,
    input  logic [`ADDR_W-1:0]   wAddr,
    input  logic [`WORD_W-1:0]   wData,
    input  logic                 wen
);

    localparam int depth = 1 << `ADDR_W;

    // source image, loaded by the testbench
    logic [`WORD_W-1:0] imageMem [depth];
    // words written back by the DUT
    logic [`WORD_W-1:0] outMem [depth];
    int writeCount = 0;

    // stale contents carry their own address, so a missed write stands out
    function automatic logic [`WORD_W-1:0] fillWord(input int addr);
        logic [`ADDR_W-1:0] a;
        logic [`WORD_W-1:0] w;
        a = addr[`ADDR_W-1:0];
        for (int j = 0; j < `WORD_W; j++) begin
            w[j] = a[j % `ADDR_W] ^ j[1];
        end
        return w;
    endfunction

    task automatic clearOutput();
        for (int i = 0; i < depth; i++) begin
            outMem[i] = fillWord(i);
        end
    endtask

    initial begin
        rData = '0;
        for (int i = 0; i < depth; i++) begin
            imageMem[i] = ~fillWord(i);
        end
        clearOutput();
    end

    // one cycle read latency, write port active low
    always @(posedge clk) begin
        rData <= imageMem[rAddr];
        if (!wen) begin
            outMem[wAddr] <= wData;
            writeCount    <= writeCount + 1;
        end
    end

endmodule

// File: ycc_defines.svh
`ifndef YCC_DEFINES_SVH
`define YCC_DEFINES_SVH

// bits per colour sample
`define PIX_W 8

// pixels packed into one sram word
`define LANES 8

`define WORD_W (`LANES * `PIX_W)

`define ADDR_W 11

// pixel groups per run, each group is three sram words
`define NUM_BLOCKS 16

// pipeline depth of one pixel converter
`define CONV_LAT 3

`endif

// File: ycc_pkg.sv
`include "ycc_defines.svh"

package ycc_pkg;

    // one colour sample
    typedef logic [`PIX_W-1:0] pixel_t;

    // read sequencer states
    typedef enum logic [1:0] {
        IDLE,
        READ,
        DRAIN
    } seqState_t;

    // plane carried by a word, also used as write phase
    typedef enum logic [1:0] {
        PLANE_R,
        PLANE_G,
        PLANE_B
    } plane_t;

endpackage
